// ==== src/knight_consts.svh ====
`ifndef KNIGHT_CONSTS_SVH
`define KNIGHT_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Motion constants of the knight command path.
////////////////////////////////////////////////////////////////////////////

`define KNIGHT_FAST_SIM 1'b1 // 1'b1 selects the large simulation steps.

// Forward speed ramp steps, 7 bits wide.
`define INC_AMT (`KNIGHT_FAST_SIM ? 7'h20 : 7'h03) // Ramp-up step per heading.
`define DEC_AMT (`KNIGHT_FAST_SIM ? 7'h40 : 7'h06) // Ramp-down step per heading.

// Heading nudges applied when a side IR sees the line.
`define NUDGE_POS (`KNIGHT_FAST_SIM ? 12'sh1FF : 12'sh05F) // Left IR, steer back.
`define NUDGE_NEG (`KNIGHT_FAST_SIM ? 12'shE00 : 12'shFA1) // Right IR, steer back.

// Error magnitude below which the robot may drive forward.
`define HDG_TOL 12'h02C

`endif

// ==== src/knight_pkg.sv ====
package knight_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Command word as it arrives over Bluetooth.
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    CAL     = 4'h2,                       // Gyro calibration.
    MOV     = 4'h4,                       // Plain move.
    FANFARE = 4'h5,                       // Move, then play the fanfare.
    TOUR    = 4'h6                        // Hand over to the tour solver.
  } opcode_t;

  typedef struct packed {
    opcode_t    opcode;                   // Bits 15..12.
    logic [7:0] hdg;                      // Heading byte, bits 11..4.
    logic [3:0] squares;                  // Squares to move, bits 3..0.
  } cmd_t;

  // IR line sensors under the chassis.
  typedef struct packed {
    logic lft;                            // Drifted right of the line.
    logic cntr;                           // Crossing a square edge.
    logic rght;                           // Drifted left of the line.
  } ir_t;

  // Everything the PID and motor drive need.
  typedef struct packed {
    logic        [9:0]  frwrd;            // Forward speed.
    logic signed [11:0] error;            // Heading error.
    logic               moving;           // Yaw integration enable.
  } motion_t;

  typedef enum logic [2:0] {
    IDLE,
    CALIBRATE,
    MOVE,
    INCR,
    DECR
  } proc_state_t;

endpackage

// ==== src/cmd_assembler.sv ====
`timescale 1ns/100ps

module cmd_assembler (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [7:0]        rx_data,
  input  logic              rx_rdy,
  input  logic              clr_cmd_rdy,
  output knight_pkg::cmd_t  cmd,
  output logic              cmd_rdy
);
  import knight_pkg::*;

  logic       byte_phase;                 // High once the first byte is in.
  logic [7:0] hi_byte;                    // Holds the high byte.
  logic       pending;                    // A finished command waits in pend_cmd.
  cmd_t       pend_cmd;                   // Command that arrived while cmd was busy.
  cmd_t       new_cmd;                    // Word formed by the second byte.
  logic       word_done;                  // Second byte strobe.
  logic       load_new;                   // New word goes straight to cmd.
  logic       load_pend;                  // Waiting word moves into cmd.
  logic       park_new;                   // New word parks in pend_cmd.

  assign new_cmd   = cmd_t'({hi_byte, rx_data});
  assign word_done = rx_rdy & byte_phase;
  assign load_pend = clr_cmd_rdy & pending;
  assign load_new  = word_done & (~cmd_rdy | (clr_cmd_rdy & ~pending));
  assign park_new  = word_done & ~load_new;

  ////////////////////////////////////////////////////////////////////////////
  // Byte phase and ready flags.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_phase <= 1'b0;
      cmd_rdy    <= 1'b0;
      pending    <= 1'b0;
    end else begin
      if (rx_rdy)
        byte_phase <= ~byte_phase;        // High byte first, then low.
      if (load_new | load_pend)
        cmd_rdy <= 1'b1;
      else if (clr_cmd_rdy)
        cmd_rdy <= 1'b0;                  // Consumed and nothing waiting.
      if (park_new)
        pending <= 1'b1;
      else if (load_pend)
        pending <= 1'b0;
    end
  end

  // Byte and command storage.
  always_ff @(posedge clk) begin
    if (rx_rdy & ~byte_phase)
      hi_byte <= rx_data;                 // cmd is untouched by a first byte.
    if (load_pend)
      cmd <= pend_cmd;
    else if (load_new)
      cmd <= new_cmd;
    if (park_new)
      pend_cmd <= new_cmd;
  end

endmodule

// ==== src/fwd_speed_ramp.sv ====
`timescale 1ns/100ps

`include "knight_consts.svh"

module fwd_speed_ramp (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       clr_frwrd,
  input  logic       inc_frwrd,
  input  logic       dec_frwrd,
  input  logic       heading_rdy,
  output logic [9:0] frwrd,
  output logic       zero
);

  logic [9:0] inc_step;                   // Ramp-up step, zero extended.
  logic [9:0] dec_step;                   // Ramp-down step, zero extended.
  logic       max_spd;                    // Top two bits set.
  logic       last_dec;                   // Next step would pass zero.

  assign inc_step = {3'b000, `INC_AMT};
  assign dec_step = {3'b000, `DEC_AMT};
  assign max_spd  = &frwrd[9:8];
  assign zero     = (frwrd == 10'h000);   // Ramp-down is over.
  assign last_dec = (frwrd <= dec_step);

  ////////////////////////////////////////////////////////////////////////////
  // Speed register, steps only with a fresh gyro heading.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frwrd <= 10'h000;
    end else if (clr_frwrd) begin
      frwrd <= 10'h000;                   // Start of a move.
    end else if (heading_rdy) begin
      if (inc_frwrd) begin
        if (!max_spd)
          frwrd <= frwrd + inc_step;      // Hold at top speed.
      end else if (dec_frwrd) begin
        if (last_dec)
          frwrd <= 10'h000;               // Land on zero, no wrap.
        else
          frwrd <= frwrd - dec_step;
      end
    end
  end

endmodule

// ==== src/square_counter.sv ====
`timescale 1ns/100ps

module square_counter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cntr_ir,
  input  logic       move_cmd,
  input  logic [3:0] squares,
  output logic       move_done
);

  logic       cntr_ir_q;                  // Centre IR one cycle back.
  logic       cntr_rise;                  // Line edge seen.
  logic [4:0] pulse_cnt;                  // Edges since the move started.
  logic [3:0] squares_q;                  // Squares of the current move.

  assign cntr_rise = cntr_ir & ~cntr_ir_q;

  ////////////////////////////////////////////////////////////////////////////
  // Edge detect and pulse count.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cntr_ir_q <= 1'b0;
      pulse_cnt <= 5'd0;
    end else begin
      cntr_ir_q <= cntr_ir;
      if (move_cmd)
        pulse_cnt <= 5'd0;                // New move, restart the count.
      else if (cntr_rise)
        pulse_cnt <= pulse_cnt + 5'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (move_cmd)
      squares_q <= squares;
  end

  // Two line crossings per square.
  assign move_done = (pulse_cnt == {squares_q, 1'b0});

endmodule

// ==== src/heading_error.sv ====
`timescale 1ns/100ps

`include "knight_consts.svh"

module heading_error (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               move_cmd,
  input  logic [7:0]         hdg,
  input  logic signed [11:0] heading,
  input  knight_pkg::ir_t    ir,
  output logic signed [11:0] error,
  output logic [11:0]        error_abs
);
  import knight_pkg::*;

  logic signed [11:0] desired_heading;    // Target heading of the move.
  logic signed [11:0] err_nudge;          // Line-following correction.

  ////////////////////////////////////////////////////////////////////////////
  // Desired heading, loaded with the move.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      desired_heading <= 12'sh000;
    end else if (move_cmd) begin
      if (hdg == 8'h00)
        desired_heading <= 12'sh000;      // North stays exactly zero.
      else
        desired_heading <= {hdg, 4'hF};
    end
  end

  // Left sensor wins when both see the line.
  always_comb begin
    if (ir.lft)
      err_nudge = `NUDGE_POS;
    else if (ir.rght)
      err_nudge = `NUDGE_NEG;
    else
      err_nudge = 12'sh000;
  end

  assign error     = heading - desired_heading + err_nudge;
  assign error_abs = error[11] ? -error : error; // Magnitude for the tolerance test.

endmodule

// ==== src/cmd_proc.sv ====
`timescale 1ns/100ps

`include "knight_consts.svh"

module cmd_proc (
  input  logic                clk,
  input  logic                rst_n,
  input  knight_pkg::cmd_t    cmd,
  input  logic                cmd_rdy,
  output logic                clr_cmd_rdy,
  input  logic                cal_done,
  input  logic signed [11:0]  heading,
  input  logic                heading_rdy,
  input  knight_pkg::ir_t     ir,
  output logic                strt_cal,
  output logic                tour_go,
  output logic                fanfare_go,
  output logic                send_resp,
  output knight_pkg::motion_t motion
);
  import knight_pkg::*;

  proc_state_t        state;              // Current state.
  proc_state_t        nxt_state;          // Next state.
  logic               move_cmd;           // Loads squares and heading.
  logic               clr_frwrd;          // Zero the speed.
  logic               inc_frwrd;          // Ramp up on headings.
  logic               dec_frwrd;          // Ramp down on headings.
  logic               moving;             // Robot under way.
  logic               zero;               // Speed is zero.
  logic               move_done;          // Enough line crossings.
  logic               fanfare_q;          // Current move ends with fanfare.
  logic [9:0]         frwrd;              // Forward speed.
  logic signed [11:0] error;              // Heading error to the PID.
  logic [11:0]        error_abs;          // Its magnitude.

  ////////////////////////////////////////////////////////////////////////////
  // Datapath.
  ////////////////////////////////////////////////////////////////////////////
  fwd_speed_ramp u_ramp (
    .clk         (clk),
    .rst_n       (rst_n),
    .clr_frwrd   (clr_frwrd),
    .inc_frwrd   (inc_frwrd),
    .dec_frwrd   (dec_frwrd),
    .heading_rdy (heading_rdy),
    .frwrd       (frwrd),
    .zero        (zero)
  );

  square_counter u_squares (
    .clk       (clk),
    .rst_n     (rst_n),
    .cntr_ir   (ir.cntr),
    .move_cmd  (move_cmd),
    .squares   (cmd.squares),
    .move_done (move_done)
  );

  heading_error u_hdg_err (
    .clk       (clk),
    .rst_n     (rst_n),
    .move_cmd  (move_cmd),
    .hdg       (cmd.hdg),
    .heading   (heading),
    .ir        (ir),
    .error     (error),
    .error_abs (error_abs)
  );

  assign motion.frwrd  = frwrd;
  assign motion.error  = error;
  assign motion.moving = moving;

  ////////////////////////////////////////////////////////////////////////////
  // State register.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      fanfare_q <= 1'b0;
    end else begin
      state <= nxt_state;
      if (move_cmd)
        fanfare_q <= (cmd.opcode == FANFARE); // cmd may change during the move.
    end
  end

  // Next state and outputs, all low unless set.
  always_comb begin
    nxt_state   = state;
    clr_cmd_rdy = 1'b0;
    strt_cal    = 1'b0;
    tour_go     = 1'b0;
    fanfare_go  = 1'b0;
    send_resp   = 1'b0;
    move_cmd    = 1'b0;
    clr_frwrd   = 1'b0;
    inc_frwrd   = 1'b0;
    dec_frwrd   = 1'b0;
    moving      = 1'b0;
    case (state)
      CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;               // Gyro is ready.
          nxt_state = IDLE;
        end
      end
      MOVE: begin
        moving = 1'b1;                    // Turning in place still counts.
        if (error_abs < `HDG_TOL) begin
          clr_frwrd = 1'b1;
          nxt_state = INCR;
        end
      end
      INCR: begin
        moving    = 1'b1;
        inc_frwrd = 1'b1;
        if (move_done) begin
          fanfare_go = fanfare_q;
          nxt_state  = DECR;
        end
      end
      DECR: begin
        dec_frwrd = 1'b1;
        if (zero) begin
          send_resp = 1'b1;               // Stopped on the square.
          nxt_state = IDLE;
        end else begin
          moving = 1'b1;
        end
      end
      default: begin
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;             // Every command is consumed here.
          case (cmd.opcode)
            TOUR: tour_go = 1'b1;         // Solver takes over, no response.
            CAL: begin
              strt_cal  = 1'b1;
              nxt_state = CALIBRATE;
            end
            MOV, FANFARE: begin
              move_cmd  = 1'b1;
              nxt_state = MOVE;
            end
            default: nxt_state = IDLE;    // Unknown opcode is dropped.
          endcase
        end
      end
    endcase
  end

endmodule

// ==== src/knight_cmd_top.sv ====
`timescale 1ns/100ps

module knight_cmd_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [7:0]          rx_data,
  input  logic                rx_rdy,
  input  logic                cal_done,
  input  logic signed [11:0]  heading,
  input  logic                heading_rdy,
  input  knight_pkg::ir_t     ir,
  output logic                strt_cal,
  output logic                tour_go,
  output logic                fanfare_go,
  output logic                send_resp,
  output knight_pkg::motion_t motion
);
  import knight_pkg::*;

  cmd_t cmd;                              // Assembled command.
  logic cmd_rdy;                          // Command waiting.
  logic clr_cmd_rdy;                      // Command taken.

  ////////////////////////////////////////////////////////////////////////////
  // UART bytes to commands, commands to motion.
  ////////////////////////////////////////////////////////////////////////////
  cmd_assembler u_assembler (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx_data     (rx_data),
    .rx_rdy      (rx_rdy),
    .clr_cmd_rdy (clr_cmd_rdy),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy)
  );

  cmd_proc u_proc (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy),
    .clr_cmd_rdy (clr_cmd_rdy),
    .cal_done    (cal_done),
    .heading     (heading),
    .heading_rdy (heading_rdy),
    .ir          (ir),
    .strt_cal    (strt_cal),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .send_resp   (send_resp),
    .motion      (motion)
  );

endmodule

// ==== testbench/tb_knight_cmd.sv ====
`timescale 1ns/100ps

`include "knight_consts.svh"

module tb_knight_cmd;
  import knight_pkg::*;

  typedef struct packed {
    logic [3:0]         op;               // Opcode of the command word.
    logic [7:0]         hdg;              // Heading byte.
    logic [3:0]         sq;               // Squares to move.
    logic signed [11:0] off;              // Start offset of the gyro heading.
    logic               sweep;            // IR sweep with random headings first.
    logic               overlap;          // TOUR bytes arrive during the move.
    logic [3:0]         exp_pls;          // Expected pulse counts, strt_cal down to send_resp.
  } entry_t;

  localparam int N_ENT    = 7;
  localparam int CAL_WAIT = 5;            // Cycles before the gyro reports done.

  logic               clk = 1'b0;
  logic               rst_n;
  logic [7:0]         rx_data;
  logic               rx_rdy;
  logic               cal_done;
  logic signed [11:0] heading;
  logic               heading_rdy;
  ir_t                ir;
  logic               strt_cal;
  logic               tour_go;
  logic               fanfare_go;
  logic               send_resp;
  motion_t            motion;
  entry_t             tbl [N_ENT];        // Stimulus and expected pulses.
  logic               table_ready = 1'b0;
  logic [15:0]        lfsr = 16'd87;      // Seed.
  int                 errors = 0;
  int                 checks = 0;
  int                 n_pls [4] = '{0, 0, 0, 0}; // Pulse counts indexed like exp_pls.
  string              pls_name [4] = '{"send_resp", "fanfare_go", "tour_go", "strt_cal"};
  logic [9:0]         prev_frwrd;         // Speed at the last sample.
  logic               hr_prev;            // heading_rdy seen by the next edge.
  logic               tol_seen;           // Error was inside tolerance this move.
  int                 limit;              // Watchdog budget in cycles.

  knight_cmd_top u_dut (
    .clk(clk), .rst_n(rst_n), .rx_data(rx_data), .rx_rdy(rx_rdy), .cal_done(cal_done),
    .heading(heading), .heading_rdy(heading_rdy), .ir(ir), .strt_cal(strt_cal),
    .tour_go(tour_go), .fanfare_go(fanfare_go), .send_resp(send_resp), .motion(motion)
  );

  always #10 clk = ~clk;                  // 20 ns period.

  always @(negedge clk) begin
    if (rst_n) begin
      n_pls[3] += strt_cal;               // Count pulses where outputs are stable.
      n_pls[2] += tour_go;
      n_pls[1] += fanfare_go;
      n_pls[0] += send_resp;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules and helpers.
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // Taps 16, 14, 13, 11.
  endfunction

  task automatic draw_bits(input int n, output logic [11:0] r);
    r = 12'h000;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);             // One step per bit.
      r    = {r[10:0], lfsr[0]};
    end
  endtask

  function automatic logic signed [11:0] des_heading(input logic [7:0] hdg);
    return (hdg == 8'h00) ? 12'sh000 : {hdg, 4'hF};
  endfunction

  function automatic logic signed [11:0] exp_error(input logic signed [11:0] h,
                                                   input logic signed [11:0] des,
                                                   input ir_t irv);
    logic signed [11:0] nudge;
    if (irv.lft)
      nudge = `NUDGE_POS;                 // Left wins over right.
    else if (irv.rght)
      nudge = `NUDGE_NEG;
    else
      nudge = 12'sh000;
    return h - des + nudge;
  endfunction

  function automatic logic [11:0] mag12(input logic signed [11:0] v);
    return v[11] ? -v : v;
  endfunction

  function automatic logic signed [11:0] step_off(input logic signed [11:0] off);
    if (off > 12'sh010)
      return off - 12'sh010;              // Gyro turns toward the target.
    else if (off < -12'sh010)
      return off + 12'sh010;
    return 12'sh000;
  endfunction

  function automatic int worst_cycles(input entry_t e);
    int n;
    n = 40 + CAL_WAIT;
    if (e.op == MOV || e.op == FANFARE) begin
      n = n + 56 + 4 * (mag12(e.off) / 16 + 1) + 16 * e.sq;
      n = n + 4 * ('h300 / `INC_AMT + 1) + 4 * ('h300 / `DEC_AMT + 1);
    end
    return n;
  endfunction

  task automatic check_val(input string name, input logic [15:0] expv,
                           input logic [15:0] actv);
    checks++;
    if (expv !== actv) begin
      errors++;
      $display("ERR time=%0t %s expected=%0h actual=%0h", $time, name, expv, actv);
    end
  endtask

  task automatic report_fail(input string msg);
    errors++;
    $display("Failure at %0t: %s", $time, msg);
  endtask

  // Sampled each cycle of a move at the falling edge.
  task automatic track_speed(input logic signed [11:0] exp_err);
    logic [9:0] now;
    logic [9:0] dn;
    now = motion.frwrd;
    dn  = (prev_frwrd <= {3'b000, `DEC_AMT}) ? 10'h000 : prev_frwrd - `DEC_AMT;
    if (mag12(exp_err) < `HDG_TOL)
      tol_seen = 1'b1;
    if (now != 10'h000 && !tol_seen)
      report_fail("forward speed rose before the heading was within tolerance");
    if (now != prev_frwrd) begin
      if (!hr_prev)
        report_fail("forward speed changed without heading_rdy");
      else if (now > prev_frwrd && prev_frwrd[9:8] == 2'b11)
        report_fail("forward speed rose past its top-bits limit");
      else if (now > prev_frwrd)
        check_val("motion.frwrd", prev_frwrd + `INC_AMT, now);
      else
        check_val("motion.frwrd", dn, now);
    end
    prev_frwrd = now;
    hr_prev    = heading_rdy;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks.
  ////////////////////////////////////////////////////////////////////////////
  task automatic send_byte(input logic [7:0] b);
    @(posedge clk);
    rx_data <= b;
    rx_rdy  <= 1'b1;                      // One-cycle strobe.
    @(posedge clk);
    rx_rdy  <= 1'b0;
  endtask

  task automatic run_cal();
    repeat (CAL_WAIT) begin
      @(negedge clk);
      check_val("send_resp", 0, send_resp); // Gyro still busy.
    end
    @(posedge clk);
    cal_done <= 1'b1;
    @(negedge clk);
    check_val("send_resp", 1, send_resp);
    @(posedge clk);
    cal_done <= 1'b0;
    @(negedge clk);
    check_val("send_resp", 0, send_resp);
  endtask

  task automatic run_move(input entry_t e);
    logic signed [11:0] des;
    logic signed [11:0] cur_off;
    logic [11:0]        h;
    ir_t                irv;
    int                 c;
    int                 edges;
    int                 cyc;
    int                 lc;
    logic               cntr_val;
    logic               at_top;
    logic               done;
    des        = des_heading(e.hdg);
    prev_frwrd = 10'h000;
    hr_prev    = 1'b0;
    tol_seen   = 1'b0;
    edges      = 2 * e.sq;                // Two line crossings per square.
    if (e.sweep) begin
      edges = edges - 1;                  // Sweep gives one cntr rise.
      for (c = 0; c < 16; c++) begin
        irv = {c[2], c[3], c[1]};         // Centre IR changes once.
        draw_bits(12, h);
        @(posedge clk);
        heading <= h;
        ir      <= irv;
        @(negedge clk);
        check_val("motion.error", exp_error(h, des, irv), motion.error);
        check_val("motion.moving", 1, motion.moving);
        track_speed(exp_error(h, des, irv));
      end
    end
    cur_off  = e.off;
    cyc      = 0;
    lc       = 0;
    cntr_val = 1'b0;
    at_top   = 1'b0;
    done     = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (cyc % 4 == 3)
        cur_off = step_off(cur_off);
      heading_rdy <= (cyc % 4 == 3);      // Gyro update every fourth cycle.
      heading     <= des + cur_off;
      if (at_top) begin
        if (lc % 4 == 0 && edges > 0) begin
          cntr_val = 1'b1;
          edges--;
        end else if (lc % 4 == 2) begin
          cntr_val = 1'b0;
        end
        lc++;
      end
      ir <= {1'b0, cntr_val, 1'b0};
      if (e.overlap && cyc == 10) begin
        rx_data <= 8'h60;                 // TOUR high byte mid-move.
        rx_rdy  <= 1'b1;
      end
      if (e.overlap && cyc == 11)
        rx_data <= 8'h00;
      if (e.overlap && cyc == 12)
        rx_rdy <= 1'b0;
      cyc++;
      @(negedge clk);
      if (motion.frwrd[9:8] == 2'b11)
        at_top = 1'b1;                    // Lines start at top speed.
      track_speed(exp_error(des + cur_off, des, 3'b000));
      if (send_resp)
        done = 1'b1;
      else
        check_val("motion.moving", 1, motion.moving);
    end
    check_val("motion.frwrd", 0, motion.frwrd);
    check_val("motion.moving", 0, motion.moving);
    @(posedge clk);
    heading_rdy <= 1'b0;
    ir          <= 3'b000;
    @(negedge clk);
    check_val("tour_go", e.overlap, tour_go); // Waiting command runs now.
    check_val("send_resp", 0, send_resp);
  endtask

  task automatic load_table();
    //            op       hdg    sq    off       sweep ovl   pulses
    tbl[0] = {CAL,     8'h00, 4'd0, 12'sh000, 1'b0, 1'b0, 4'b1001};
    tbl[1] = {TOUR,    8'h00, 4'd0, 12'sh000, 1'b0, 1'b0, 4'b0100};
    tbl[2] = {MOV,     8'h00, 4'd1, 12'sh100, 1'b1, 1'b0, 4'b0001};
    tbl[3] = {FANFARE, 8'h40, 4'd2, 12'shF40, 1'b1, 1'b0, 4'b0011};
    tbl[4] = {MOV,     8'hC0, 4'd3, 12'sh080, 1'b0, 1'b1, 4'b0101};
    tbl[5] = {CAL,     8'h00, 4'd0, 12'sh000, 1'b0, 1'b0, 4'b1001};
    tbl[6] = {FANFARE, 8'h7F, 4'd1, 12'sh020, 1'b1, 1'b0, 4'b0011};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog.
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    entry_t e;
    int     i;
    int     k;
    int     snap [4];
    rst_n       = 1'b0;
    rx_data     = 8'h00;
    rx_rdy      = 1'b0;
    cal_done    = 1'b0;
    heading     = 12'sh000;
    heading_rdy = 1'b0;
    ir          = 3'b000;
    load_table();
    table_ready = 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_val("strt_cal", 0, strt_cal);   // Quiet after reset.
    check_val("tour_go", 0, tour_go);
    check_val("fanfare_go", 0, fanfare_go);
    check_val("send_resp", 0, send_resp);
    check_val("motion.frwrd", 0, motion.frwrd);
    check_val("motion.moving", 0, motion.moving);
    for (i = 0; i < N_ENT; i++) begin
      e = tbl[i];
      @(posedge clk);
      snap = n_pls;
      send_byte({e.op, e.hdg[7:4]});      // High byte first.
      send_byte({e.hdg[3:0], e.sq});
      @(negedge clk);
      check_val("strt_cal", e.op == CAL, strt_cal); // One cycle after the byte.
      check_val("tour_go", e.op == TOUR, tour_go);
      if (e.op == CAL)
        run_cal();
      else if (e.op == MOV || e.op == FANFARE)
        run_move(e);
      repeat (4) @(posedge clk);
      for (k = 0; k < 4; k++)
        check_val($sformatf("%s count of entry %0d", pls_name[k], i),
                  e.exp_pls[k], n_pls[k] - snap[k]);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial begin
    int j;
    wait (table_ready);
    limit = 20;                           // Reset and closing cycles.
    for (j = 0; j < N_ENT; j++)
      limit = limit + worst_cycles(tbl[j]);
    #(limit * 20);
    $display("Timeout: the tests did not finish within %0d cycles", limit);
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+src
src/knight_pkg.sv
src/cmd_assembler.sv
src/fwd_speed_ramp.sv
src/square_counter.sv
src/heading_error.sv
src/cmd_proc.sv
src/knight_cmd_top.sv
testbench/tb_knight_cmd.sv
